// File: tb.f
design/rob_pkg.sv
design/rob_cmt_ptr.sv
design/rob_entry.sv
design/rob_commit_ctrl.sv
design/rob_top.sv
testbench/tb_rob.sv

// File: Bender.yml
package:
  name: rob

sources:
  - design/rob_pkg.sv
  - design/rob_cmt_ptr.sv
  - design/rob_entry.sv
  - design/rob_commit_ctrl.sv
  - design/rob_top.sv
  - target: simulation
    files:
      - testbench/tb_rob.sv

// File: testbench/tb_rob.sv
`timescale 1ns/1ns

module tb_rob;
  import rob_pkg::*;

  localparam int NUM_ROWS = 20;
  localparam int TIMEOUT  = 200;  // cycles per wait loop

  typedef struct packed {
    logic [3:0]            test;
    logic [DISP_SIZE-1:0]  mask;
    logic [XLEN_W-1:0]     pc;
    except_t               type0;
    logic [XLEN_W-1:0]     tval0;
    except_t               type1;
    logic [XLEN_W-1:0]     tval1;
    logic [DISP_SIZE-1:0]  br;
  } row_t;

  // test, lane mask, base pc, lane 0 type/tval, lane 1 type/tval, branch flags
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'd2, 2'b11, 32'h0000_1000, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd2, 2'b01, 32'h0000_1010, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd2, 2'b11, 32'h0000_1020, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd3, 2'b11, 32'h0000_2000, NONE, 32'h0, NONE, 32'h0, 2'b01},
    '{4'd3, 2'b11, 32'h0000_2010, NONE, 32'h0, NONE, 32'h0, 2'b10},
    '{4'd4, 2'b11, 32'h0000_3000, NONE, 32'h0, ILLEGAL_INST, 32'hdead_beef, 2'b00},
    '{4'd5, 2'b11, 32'h0000_3100, INST_ADDR_MISALIGN, 32'h1234, NONE, 32'h0, 2'b00},
    '{4'd6, 2'b11, 32'h0000_4000, LOAD_ACC_FAULT, 32'h8000_0010, NONE, 32'h0, 2'b00},
    '{4'd6, 2'b01, 32'h0000_4010, ECALL_M, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd6, 2'b11, 32'h0000_4020, NONE, 32'h0, NONE, 32'h0, 2'b01},
    '{4'd7, 2'b11, 32'h0000_5000, NONE, 32'h0, INST_ACC_FAULT, 32'h77, 2'b00},
    '{4'd8, 2'b11, 32'h0000_6000, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b01, 32'h0000_6010, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b11, 32'h0000_6020, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b01, 32'h0000_6030, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b11, 32'h0000_6040, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b11, 32'h0000_6050, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b01, 32'h0000_6060, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd8, 2'b11, 32'h0000_6070, NONE, 32'h0, NONE, 32'h0, 2'b00},
    '{4'd9, 2'b11, 32'h0000_7000, NONE, 32'h0, LOAD_ACC_FAULT, 32'h99, 2'b01}
  };

  logic                 i_clk;
  logic                 i_reset_n;
  disp_t                i_disp;
  done_rpt_t            i_done_rpt [DONE_PORTS];
  logic [CMT_ID_W-1:0]  o_new_cmt_id;
  logic                 o_rob_full;
  commit_blk_t          o_commit;

  commit_blk_t          exp_q [$];   // reference commits, oldest first
  done_rpt_t            rpt_q [$];
  commit_blk_t          mon_exp;
  logic [CMT_ID_W-1:0]  next_id;
  int                   check_cnt;
  int                   error_cnt;
  int                   commit_cnt;
  bit                   timed_out;

  rob_top rob_top_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_done_rpt   (i_done_rpt),
    .o_new_cmt_id (o_new_cmt_id),
    .o_rob_full   (o_rob_full),
    .o_commit     (o_commit)
  );

  always #4 i_clk = ~i_clk;

  // ----------------------------------------
  // helpers and reference model
  // ----------------------------------------
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic except_t lane_type(input row_t r, input int d);
    return (d == 0) ? r.type0 : r.type1;
  endfunction

  function automatic logic [XLEN_W-1:0] lane_tval(input row_t r, input int d);
    return (d == 0) ? r.tval0 : r.tval1;
  endfunction

  function automatic commit_blk_t expected_commit(input row_t r, input logic [CMT_ID_W-1:0] id,
                                                  input bit killed);
    commit_blk_t b;
    bit          br_seen;
    bit          ex_seen;
    bit          upd_seen;
    except_t     ty;
    b             = '0;
    b.commit      = 1'b1;
    b.cmt_id      = id;
    b.grp_id      = r.mask;
    b.except_type = NONE;
    br_seen       = 1'b0;
    ex_seen       = 1'b0;
    upd_seen      = 1'b0;
    if (killed) begin       // younger than a trap, retired as all dead
      b.dead_id  = r.mask;
      b.all_dead = 1'b1;
      return b;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      ty = lane_type(r, d);
      if (r.mask[d] && (br_seen || ex_seen)) b.dead_id[d] = 1'b1;
      if (r.mask[d] && !upd_seen && (r.br[d] || ty != NONE)) begin
        upd_seen = 1'b1;      // first lane that redirects the pc
        if (ty != NONE) begin
          b.except_valid[d] = 1'b1;
          b.except_type     = ty;
          b.epc             = r.pc + XLEN_W'(4 * d);
          b.tval = (ty == INST_ADDR_MISALIGN || ty == INST_ACC_FAULT) ? b.epc : lane_tval(r, d);
        end
      end
      br_seen = br_seen | (r.mask[d] & r.br[d]);
      ex_seen = ex_seen | (r.mask[d] & (ty != NONE));
    end
    b.all_dead = (b.dead_id == r.mask);
    return b;
  endfunction

  task automatic queue_reports(input row_t r, input logic [CMT_ID_W-1:0] id);
    done_rpt_t rpt;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (r.mask[d]) begin
        rpt              = '0;
        rpt.valid        = 1'b1;
        rpt.cmt_id       = id;
        rpt.grp_id       = DISP_SIZE'(1) << d;
        rpt.except_type  = lane_type(r, d);
        rpt.except_valid = (rpt.except_type != NONE);
        rpt.except_tval  = lane_tval(r, d);
        rpt.br_upd_valid = r.br[d];
        rpt_q.push_back(rpt);
      end
    end
  endtask

  // fisher-yates over the pending reports
  task automatic shuffle_reports();
    done_rpt_t tmp;
    int        j;
    for (int i = rpt_q.size() - 1; i > 0; i--) begin
      j        = $urandom % (i + 1);
      tmp      = rpt_q[i];
      rpt_q[i] = rpt_q[j];
      rpt_q[j] = tmp;
    end
  endtask

  task automatic send_reports();
    while (rpt_q.size() > 0) begin
      @(posedge i_clk);
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (rpt_q.size() > 0) i_done_rpt[p] <= rpt_q.pop_front();
        else i_done_rpt[p] <= '0;
      end
    end
    @(posedge i_clk);
    for (int p = 0; p < DONE_PORTS; p++) i_done_rpt[p] <= '0;
  endtask

  task automatic wait_not_full();
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while (o_rob_full && cnt < TIMEOUT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (o_rob_full) begin
      timed_out = 1'b1;
      error_cnt++;
      $display("timeout: buffer stayed full, dispatch could not go on");
    end
  endtask

  task automatic wait_drained(input int t);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      timed_out = 1'b1;
      error_cnt++;
      $display("timeout in test %0d: %0d expected commits never came", t, exp_q.size());
    end
  endtask

  // ----------------------------------------
  // commit monitor
  // ----------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_commit.commit) begin
      commit_cnt++;
      if (exp_q.size() == 0) begin
        error_cnt++;
        $display("commit of id 0x%0h arrived with no group outstanding", o_commit.cmt_id);
      end else begin
        mon_exp = exp_q.pop_front();
        compare("o_commit.cmt_id", o_commit.cmt_id, mon_exp.cmt_id);
        compare("o_commit.grp_id", o_commit.grp_id, mon_exp.grp_id);
        compare("o_commit.except_valid", o_commit.except_valid, mon_exp.except_valid);
        compare("o_commit.except_type", o_commit.except_type, mon_exp.except_type);
        compare("o_commit.epc", o_commit.epc, mon_exp.epc);
        compare("o_commit.tval", o_commit.tval, mon_exp.tval);
        compare("o_commit.dead_id", o_commit.dead_id, mon_exp.dead_id);
        compare("o_commit.all_dead", o_commit.all_dead, mon_exp.all_dead);
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int          row;
    int          first;
    int          e0;
    logic [3:0]  t;
    bit          killed;
    commit_blk_t blk;
    void'($urandom(32'h4b5a_4539));
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    i_disp    = '0;
    for (int p = 0; p < DONE_PORTS; p++) i_done_rpt[p] = '0;
    next_id   = '0;
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    compare("o_commit.commit", o_commit.commit, 1'b0);
    compare("o_new_cmt_id", o_new_cmt_id, '0);
    compare("o_rob_full", o_rob_full, 1'b0);
    $display("test 1: %s", (error_cnt == 0) ? "ok" : "failed");

    row = 0;
    while (row < NUM_ROWS && !timed_out) begin
      first  = row;
      t      = ROWS[row].test;
      killed = 1'b0;
      e0     = error_cnt;
      // dispatch the whole group of rows first, no reports yet
      while (row < NUM_ROWS && ROWS[row].test == t && !timed_out) begin
        wait_not_full();
        if (!timed_out) begin
          compare("o_new_cmt_id", o_new_cmt_id, next_id);
          blk = expected_commit(ROWS[row], next_id, killed);
          exp_q.push_back(blk);
          killed = killed | (|blk.except_valid);
          queue_reports(ROWS[row], next_id);
          @(posedge i_clk);
          i_disp <= '{valid: 1'b1, pc_addr: ROWS[row].pc, inst_valid: ROWS[row].mask};
          @(posedge i_clk);
          i_disp <= '0;
          next_id = next_id + 1'b1;
          row++;
        end
      end
      if (!timed_out) begin
        @(negedge i_clk);
        compare("o_rob_full", o_rob_full, (row - first) == CMT_ENTRY_SIZE);
        shuffle_reports();
        send_reports();
        wait_drained(t);
        $display("test %0d: %s", t, (error_cnt == e0) ? "ok" : "failed");
      end
    end

    $display("summary: %0d checks, %0d commits, %0d errors", check_cnt, commit_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ns

module rob_top (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  rob_pkg::disp_t                i_disp,
  input  rob_pkg::done_rpt_t            i_done_rpt [rob_pkg::DONE_PORTS],
  output logic [rob_pkg::CMT_ID_W-1:0]  o_new_cmt_id,
  output logic                          o_rob_full,
  output rob_pkg::commit_blk_t          o_commit
);
  import rob_pkg::*;

  logic [CMT_ID_W-1:0]        w_in_ptr;
  logic [CMT_ID_W-1:0]        w_out_ptr;
  logic                       w_full;
  logic                       w_retire;
  logic                       w_flush;
  logic [CMT_ENTRY_SIZE-1:0]  w_finish_oh;
  logic [CMT_ENTRY_SIZE-1:0]  w_all_done;
  rob_entry_t                 w_entries [CMT_ENTRY_SIZE];
  rob_entry_t                 w_head;

  // ----------------------------------------
  // pointers
  // ----------------------------------------
  rob_cmt_ptr u_cmt_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp.valid),
    .i_out_valid (w_retire),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_full      (w_full)
  );

  // ----------------------------------------
  // entry array
  // ----------------------------------------
  for (genvar g = 0; g < CMT_ENTRY_SIZE; g++) begin : g_entry
    rob_entry #(.ENTRY_IDX(g)) u_entry (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_load_valid    (i_disp.valid),   // entry decodes its own slot
      .i_disp          (i_disp),
      .i_load_cmt_id   (w_in_ptr),
      .i_done_rpt      (i_done_rpt),
      .i_kill          (w_flush),
      .i_commit_finish (w_finish_oh[g]),
      .o_entry         (w_entries[g]),
      .o_all_done      (w_all_done[g])
    );
  end

  assign w_head = w_entries[w_out_ptr[CMT_ENTRY_W-1:0]];

  // ----------------------------------------
  // commit
  // ----------------------------------------
  rob_commit_ctrl u_commit_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_head          (w_head),
    .i_head_all_done (w_all_done[w_out_ptr[CMT_ENTRY_W-1:0]]),
    .i_out_ptr       (w_out_ptr),
    .o_retire        (w_retire),
    .o_flush         (w_flush),
    .o_finish_oh     (w_finish_oh),
    .o_commit        (o_commit)
  );

  assign o_new_cmt_id = w_in_ptr;
  assign o_rob_full   = w_full;

endmodule

// File: design/rob_commit_ctrl.sv
`timescale 1ns/1ns

module rob_commit_ctrl (
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  input  rob_pkg::rob_entry_t                i_head,
  input  logic                               i_head_all_done,
  input  logic [rob_pkg::CMT_ID_W-1:0]       i_out_ptr,
  output logic                               o_retire,
  output logic                               o_flush,
  output logic [rob_pkg::CMT_ENTRY_SIZE-1:0] o_finish_oh,
  output rob_pkg::commit_blk_t               o_commit
);
  import rob_pkg::*;

  // lanes strictly above the lowest set bit
  function automatic logic [DISP_SIZE-1:0] above_first(input logic [DISP_SIZE-1:0] v);
    logic [DISP_SIZE-1:0] res;
    logic                 seen;
    res  = '0;
    seen = 1'b0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      res[d] = seen;
      seen   = seen | v[d];
    end
    return res;
  endfunction

  logic                  r_killing;   // draining younger groups after a trap
  logic                  w_head_killed;
  logic                  w_kill_commit;
  logic                  w_commit;
  logic [DISP_SIZE-1:0]  w_upd_cand;
  logic [DISP_SIZE-1:0]  w_upd_oh;
  logic [DISP_SIZE-1:0]  w_except_oh;
  except_t               w_sel_type;
  logic [XLEN_W-1:0]     w_sel_tval;
  logic [XLEN_W-1:0]     w_sel_pc;
  logic [DISP_SIZE-1:0]  w_dead_id;

  assign w_head_killed = i_head.valid & (&i_head.dead);
  assign w_kill_commit = r_killing & w_head_killed;
  assign w_commit      = i_head_all_done | w_kill_commit;

  // ----------------------------------------
  // pc update lane and exception select
  // ----------------------------------------
  assign w_upd_cand  = (i_head.br_upd_valid | i_head.except_valid) & i_head.done_grp_id;
  assign w_upd_oh    = w_upd_cand & (~w_upd_cand + 1'b1);  // lowest lane wins
  assign w_except_oh = i_head.except_valid & w_upd_oh &
                       {DISP_SIZE{w_commit & ~w_kill_commit}};

  always_comb begin
    w_sel_type = NONE;
    w_sel_tval = '0;
    w_sel_pc   = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_except_oh[d]) begin
        w_sel_type = i_head.except_type[d];
        w_sel_tval = i_head.except_tval[d];
        w_sel_pc   = i_head.pc_addr + XLEN_W'(4 * d);
      end
    end
  end

  assign w_dead_id = (i_head.dead |
                      above_first(i_head.br_upd_valid) |
                      above_first(i_head.except_valid)) & i_head.grp_id;

  // ----------------------------------------
  // kill state
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_killing <= 1'b0;
    end else if (o_flush) begin
      r_killing <= 1'b1;
    end else if (r_killing & ~w_head_killed) begin
      r_killing <= 1'b0;          // nothing killed left at the head
    end
  end

  assign o_flush     = |w_except_oh;
  assign o_retire    = w_commit;
  assign o_finish_oh = w_commit ? (CMT_ENTRY_SIZE'(1) << i_out_ptr[CMT_ENTRY_W-1:0]) : '0;

  assign o_commit.commit       = w_commit;
  assign o_commit.cmt_id       = i_out_ptr;
  assign o_commit.grp_id       = i_head.grp_id;
  assign o_commit.except_valid = w_except_oh;
  assign o_commit.except_type  = w_sel_type;
  assign o_commit.epc          = w_sel_pc;
  // fetch-side faults report the faulting pc itself
  assign o_commit.tval         = ((w_sel_type == INST_ADDR_MISALIGN) ||
                                  (w_sel_type == INST_ACC_FAULT)) ? w_sel_pc : w_sel_tval;
  assign o_commit.dead_id      = w_dead_id;
  assign o_commit.all_dead     = w_kill_commit | (w_dead_id == i_head.grp_id);

endmodule

// File: design/rob_entry.sv
`timescale 1ns/1ns

module rob_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_load_valid,
  input  rob_pkg::disp_t               i_disp,
  input  logic [rob_pkg::CMT_ID_W-1:0] i_load_cmt_id,
  input  rob_pkg::done_rpt_t           i_done_rpt [rob_pkg::DONE_PORTS],
  input  logic                         i_kill,
  input  logic                         i_commit_finish,
  output rob_pkg::rob_entry_t          o_entry,
  output logic                         o_all_done
);
  import rob_pkg::*;

  localparam logic [CMT_ENTRY_W-1:0] MY_IDX = CMT_ENTRY_W'(ENTRY_IDX);

  logic                              r_valid;
  logic [DISP_SIZE-1:0]              r_done;
  logic [DISP_SIZE-1:0]              r_dead;
  logic [DISP_SIZE-1:0]              r_except_valid;
  logic [DISP_SIZE-1:0]              r_br_upd_valid;
  logic [CMT_ID_W-1:0]               r_cmt_id;   // full id incl. wrap bit
  logic [XLEN_W-1:0]                 r_pc_addr;
  logic [DISP_SIZE-1:0]              r_grp_id;
  except_t [DISP_SIZE-1:0]           r_except_type;
  logic [DISP_SIZE-1:0][XLEN_W-1:0]  r_except_tval;

  logic                              w_load;
  logic                              w_accept;
  logic [DONE_PORTS-1:0]             w_hit;

  assign w_load   = i_load_valid & (i_load_cmt_id[CMT_ENTRY_W-1:0] == MY_IDX);
  assign w_accept = r_valid & ~(&r_dead);  // killed entries take no reports

  always_comb begin
    for (int p = 0; p < DONE_PORTS; p++) begin
      w_hit[p] = w_accept & i_done_rpt[p].valid & (i_done_rpt[p].cmt_id == r_cmt_id);
    end
  end

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_done         <= '0;
      r_dead         <= '0;
      r_except_valid <= '0;
      r_br_upd_valid <= '0;
    end else if (w_load) begin
      r_valid        <= 1'b1;
      r_done         <= '0;
      r_dead         <= '0;
      r_except_valid <= '0;
      r_br_upd_valid <= '0;
    end else begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (w_hit[p] & i_done_rpt[p].grp_id[d]) begin
            r_done[d]         <= 1'b1;
            r_except_valid[d] <= i_done_rpt[p].except_valid;
            r_br_upd_valid[d] <= i_done_rpt[p].br_upd_valid;
          end
        end
      end
      if (i_kill & r_valid) r_dead <= '1;     // whole group dies
      if (i_commit_finish) r_valid <= 1'b0;
    end
  end

  // ----------------------------------------
  // payload
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_cmt_id  <= i_load_cmt_id;
      r_pc_addr <= i_disp.pc_addr;
      r_grp_id  <= i_disp.inst_valid;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_hit[p] & i_done_rpt[p].grp_id[d]) begin
          r_except_type[d] <= i_done_rpt[p].except_type;
          r_except_tval[d] <= i_done_rpt[p].except_tval;
        end
      end
    end
  end

  assign o_entry.valid        = r_valid;
  assign o_entry.pc_addr      = r_pc_addr;
  assign o_entry.grp_id       = r_grp_id;
  assign o_entry.done_grp_id  = r_done;
  assign o_entry.dead         = r_dead;
  assign o_entry.except_valid = r_except_valid;
  assign o_entry.except_type  = r_except_type;
  assign o_entry.except_tval  = r_except_tval;
  assign o_entry.br_upd_valid = r_br_upd_valid;

  assign o_all_done = r_valid & ((r_done & r_grp_id) == r_grp_id);

endmodule

// File: design/rob_cmt_ptr.sv
`timescale 1ns/1ns

module rob_cmt_ptr (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_in_valid,
  input  logic                          i_out_valid,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_in_ptr,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_out_ptr,
  output logic                          o_full
);
  import rob_pkg::*;

  logic [CMT_ID_W-1:0] r_in_ptr;
  logic [CMT_ID_W-1:0] r_out_ptr;

  // index bits wrap on their own, the msb toggles every lap
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_in_valid)  r_in_ptr  <= r_in_ptr + 1'b1;
      if (i_out_valid) r_out_ptr <= r_out_ptr + 1'b1;
    end
  end

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;
  assign o_full    = (r_in_ptr[CMT_ENTRY_W-1:0] == r_out_ptr[CMT_ENTRY_W-1:0]) &
                     (r_in_ptr[CMT_ID_W-1] != r_out_ptr[CMT_ID_W-1]);  // same slot, other lap

endmodule

// File: design/rob_pkg.sv
package rob_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int DISP_SIZE      = 2;   // lanes per group
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;
  localparam int CMT_ID_W       = 4;   // entry index + wrap bit
  localparam int DONE_PORTS     = 2;
  localparam int XLEN_W         = 32;

  // riscv cause numbering, NONE parked on an unused code
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    LOAD_ACC_FAULT     = 4'd5,
    ECALL_M            = 4'd11,
    NONE               = 4'd15
  } except_t;

  // ----------------------------------------
  // dispatch and completion
  // ----------------------------------------
  typedef struct packed {
    logic                  valid;
    logic [XLEN_W-1:0]     pc_addr;     // lane n sits at pc_addr + 4*n
    logic [DISP_SIZE-1:0]  inst_valid;
  } disp_t;

  typedef struct packed {
    logic                  valid;
    logic [CMT_ID_W-1:0]   cmt_id;
    logic [DISP_SIZE-1:0]  grp_id;      // one-hot lane
    logic                  except_valid;
    except_t               except_type;
    logic [XLEN_W-1:0]     except_tval;
    logic                  br_upd_valid;
  } done_rpt_t;

  // ----------------------------------------
  // entry state and commit block
  // ----------------------------------------
  typedef struct packed {
    logic                              valid;
    logic [XLEN_W-1:0]                 pc_addr;
    logic [DISP_SIZE-1:0]              grp_id;
    logic [DISP_SIZE-1:0]              done_grp_id;
    logic [DISP_SIZE-1:0]              dead;
    logic [DISP_SIZE-1:0]              except_valid;
    except_t [DISP_SIZE-1:0]           except_type;
    logic [DISP_SIZE-1:0][XLEN_W-1:0]  except_tval;
    logic [DISP_SIZE-1:0]              br_upd_valid;
  } rob_entry_t;

  typedef struct packed {
    logic                  commit;
    logic [CMT_ID_W-1:0]   cmt_id;
    logic [DISP_SIZE-1:0]  grp_id;
    logic [DISP_SIZE-1:0]  except_valid;  // one-hot
    except_t               except_type;
    logic [XLEN_W-1:0]     epc;
    logic [XLEN_W-1:0]     tval;
    logic [DISP_SIZE-1:0]  dead_id;
    logic                  all_dead;
  } commit_blk_t;

endpackage
